/* dot_product_top.f */
+incdir+include
source/dot_pkg.sv
source/mac_lane_if.sv
source/dot_sequencer.sv
source/mac_lane.sv
source/lane_combiner.sv
source/dot_product_top.sv
tests/dot_product_properties.sv
tests/dot_product_tb.sv

/* run.sh */
#!/bin/sh
# build and run the dot product testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=dot_product_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module dot_product_tb -f dot_product_top.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

echo "simulation passed"
exit 0

/* tests/dot_product_tb.sv */
// dot product engine testbench
`timescale 1ns/1ps
`default_nettype none

`include "dot_macros.svh"

module dot_product_tb;

    localparam int NUM_VECTORS = 6;
    localparam int MAX_PAIRS = 20;
    // random vectors plus directed tests and idle cycles
    localparam int MAX_CMDS = NUM_VECTORS * (MAX_PAIRS + 2) + 40;
    localparam int TIMEOUT_CYCLES = MAX_CMDS * 4 + 100;
    localparam logic signed [63:0] ACC_MAX = (64'sd1 <<< (`DOT_ACC_W - 1)) - 64'sd1;
    localparam logic signed [63:0] ACC_MIN = -(64'sd1 <<< (`DOT_ACC_W - 1));
    localparam logic signed [`DOT_IN_W-1:0] IN_MAX = {1'b0, {(`DOT_IN_W-1){1'b1}}};
    localparam logic signed [`DOT_IN_W-1:0] IN_MIN = {1'b1, {(`DOT_IN_W-1){1'b0}}};

    logic                         clk_i;
    logic                         rst_i;
    logic                         cmd_valid_i;
    dot_pkg::opcode_e             op_i;
    logic signed [`DOT_IN_W-1:0]  a0_i;
    logic signed [`DOT_IN_W-1:0]  b0_i;
    logic signed [`DOT_IN_W-1:0]  a1_i;
    logic signed [`DOT_IN_W-1:0]  b1_i;
    logic signed [`DOT_ACC_W-1:0] result_o;
    logic                         result_valid_o;
    logic                         overflow_o;
    logic                         busy_o;

    integer                       seed;
    int                           cycle_cnt = 0;
    logic signed [`DOT_ACC_W-1:0] sum0;  // model lane sums that wrap like hardware
    logic signed [`DOT_ACC_W-1:0] sum1;
    logic                         ovf0;  // model sticky lane flags
    logic                         ovf1;

    dot_product_top dut_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .cmd_valid_i    (cmd_valid_i),
        .op_i           (op_i),
        .a0_i           (a0_i),
        .b0_i           (b0_i),
        .a1_i           (a1_i),
        .b1_i           (b1_i),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .overflow_o     (overflow_o),
        .busy_o         (busy_o)
    );

    always #10 clk_i = ~clk_i;  // 20 ns period

    // run limit
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("simulation timed out after %0d cycles", cycle_cnt);
            report_failure();
        end
    end

    // bound checker flags a broken port rule
    always @(posedge clk_i) begin
        if (dut_i.props_u.assert_failed) begin
            $display("bound assertion failed before %0t", $time);
            report_failure();
        end
    end

    task automatic report_failure();
        $display("Errors found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input logic signed [`DOT_ACC_W-1:0] got,
                              input logic signed [`DOT_ACC_W-1:0] exp);
        assert (got == exp) else begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got == exp) else begin
            $display("MISMATCH at %0t: %s got %0b expected %0b", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_int(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
            report_failure();
        end
    endtask

    function automatic logic signed [`DOT_IN_W-1:0] rand_operand();
        logic [31:0] r;
        r = $random(seed);
        return r[`DOT_IN_W-1:0];
    endfunction

    // one lane add that wraps and flags like a 2's complement accumulator
    task automatic model_step(inout logic signed [`DOT_ACC_W-1:0] acc, inout logic ovf,
                              input logic signed [`DOT_IN_W-1:0] a,
                              input logic signed [`DOT_IN_W-1:0] b);
        logic signed [63:0] exact;
        exact = 64'(acc) + 64'(a) * 64'(b);
        acc = exact[`DOT_ACC_W-1:0];
        if ((exact > ACC_MAX) || (exact < ACC_MIN)) begin
            ovf = 1'b1;
        end
    endtask

    // operands change just after the edge and are sampled on the next one
    task automatic drive_cmd(input dot_pkg::opcode_e op, input logic signed [`DOT_IN_W-1:0] a0,
                             input logic signed [`DOT_IN_W-1:0] b0,
                             input logic signed [`DOT_IN_W-1:0] a1,
                             input logic signed [`DOT_IN_W-1:0] b1);
        @(posedge clk_i);
        cmd_valid_i <= 1'b1;
        op_i        <= op;
        a0_i        <= a0;
        b0_i        <= b0;
        a1_i        <= a1;
        b1_i        <= b1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            cmd_valid_i <= 1'b0;
            op_i        <= dot_pkg::OP_NOP;
        end
        @(negedge clk_i);  // settled outputs
    endtask

    task automatic do_clear();
        drive_cmd(dot_pkg::OP_CLEAR, '0, '0, '0, '0);
        sum0 = '0;
        sum1 = '0;
        ovf0 = 1'b0;
        ovf1 = 1'b0;
    endtask

    task automatic do_accum_pair(input logic signed [`DOT_IN_W-1:0] a0,
                                 input logic signed [`DOT_IN_W-1:0] b0,
                                 input logic signed [`DOT_IN_W-1:0] a1,
                                 input logic signed [`DOT_IN_W-1:0] b1);
        drive_cmd(dot_pkg::OP_ACCUM, a0, b0, a1, b1);
        model_step(sum0, ovf0, a0, b0);  // even elements
        model_step(sum1, ovf1, a1, b1);  // odd elements
    endtask

    task automatic do_accum(input int pairs);
        repeat (pairs) begin
            do_accum_pair(rand_operand(), rand_operand(), rand_operand(), rand_operand());
        end
    endtask

    // finish and optionally throw commands at the busy engine
    task automatic do_finish_and_check(input logic inject);
        logic signed [63:0]           total;
        logic signed [`DOT_ACC_W-1:0] exp_res;
        logic                         sat;
        int                           cycles;
        total = 64'(sum0) + 64'(sum1);
        sat = 1'b1;
        if (total > ACC_MAX) begin
            exp_res = ACC_MAX[`DOT_ACC_W-1:0];
        end else if (total < ACC_MIN) begin
            exp_res = ACC_MIN[`DOT_ACC_W-1:0];
        end else begin
            exp_res = total[`DOT_ACC_W-1:0];
            sat = 1'b0;
        end
        drive_cmd(dot_pkg::OP_FINISH, '0, '0, '0, '0);
        @(posedge clk_i);  // accept edge
        cmd_valid_i <= inject;
        op_i        <= inject ? dot_pkg::OP_CLEAR : dot_pkg::OP_NOP;
        cycles = 0;
        @(negedge clk_i);
        while (!result_valid_o) begin
            check_bit("busy_o", busy_o, 1'b1);
            if (cycles >= 6) begin
                $display("result_valid_o never arrived after finish at %0t", $time);
                report_failure();
            end
            @(posedge clk_i);
            cmd_valid_i <= inject && (cycles < 2);  // last one lands in emit
            op_i        <= dot_pkg::OP_ACCUM;
            a0_i        <= rand_operand();
            b0_i        <= rand_operand();
            a1_i        <= rand_operand();
            b1_i        <= rand_operand();
            @(negedge clk_i);
            cycles++;
        end
        check_int("result latency", cycles, 3);
        check_bit("busy_o", busy_o, 1'b0);
        check_word("result_o", result_o, exp_res);
        check_bit("overflow_o", overflow_o, ovf0 | ovf1 | sat);
    endtask

    initial begin
        seed        = 32'hc88b_61ff;
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        cmd_valid_i = 1'b0;
        op_i        = dot_pkg::OP_NOP;
        a0_i        = '0;
        b0_i        = '0;
        a1_i        = '0;
        b1_i        = '0;
        sum0        = '0;
        sum1        = '0;
        ovf0        = 1'b0;
        ovf1        = 1'b0;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;

        do_finish_and_check(1'b0);  // empty engine gives zero

        // random vectors cleared in between
        for (int v = 0; v < NUM_VECTORS; v++) begin
            do_clear();
            do_accum(int'($unsigned($random(seed)) % 32'd20) + 1);
            do_finish_and_check(1'b0);
        end

        // old pairs must not leak past a clear
        do_clear();
        do_accum(5);
        do_clear();
        do_accum(3);
        do_finish_and_check(1'b0);

        // lane 0 wraps and its flag sticks until clear
        do_clear();
        do_accum_pair(IN_MIN, IN_MIN, 16'sd3, -16'sd7);
        do_accum_pair(IN_MIN, IN_MIN, 16'sd5, 16'sd9);
        idle_cycles(4);
        check_bit("overflow_o", overflow_o, 1'b1);
        do_finish_and_check(1'b0);
        idle_cycles(2);
        check_bit("overflow_o", overflow_o, 1'b1);
        do_clear();
        idle_cycles(3);
        check_bit("overflow_o", overflow_o, 1'b0);

        // lanes fit but the total saturates high then low
        do_clear();
        do_accum_pair(IN_MIN, IN_MIN, IN_MIN, IN_MIN);
        do_accum_pair(IN_MAX, IN_MAX, IN_MAX, IN_MAX);
        do_finish_and_check(1'b0);
        do_clear();
        do_accum_pair(IN_MIN, IN_MAX, IN_MIN, IN_MAX);
        do_accum_pair(IN_MIN, IN_MAX, IN_MIN, IN_MAX);
        do_finish_and_check(1'b0);
        idle_cycles(1);
        check_bit("overflow_o", overflow_o, ovf0 | ovf1);

        // busy engine drops clear and accumulate commands
        do_clear();
        do_accum(4);
        do_finish_and_check(1'b1);
        do_finish_and_check(1'b0);

        idle_cycles(2);  // port rules see the last pulse
        if (dut_i.props_u.assert_failed) begin
            $display("bound assertion failed before %0t", $time);
            report_failure();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tests/dot_product_properties.sv */
// dot product port assertions
`timescale 1ns/1ps
`default_nettype none

module dot_product_properties (
    input wire logic             clk_i,
    input wire logic             rst_i,
    input wire logic             cmd_valid_i,
    input wire dot_pkg::opcode_e op_i,
    input wire logic             busy_o,
    input wire logic             result_valid_o
);

    logic finish_pending_q;      // finish accepted but result not yet out
    logic assert_failed = 1'b0;  // set by any failing assertion

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            finish_pending_q <= 1'b0;
        end else if (cmd_valid_i && !busy_o && (op_i == dot_pkg::OP_FINISH)) begin
            finish_pending_q <= 1'b1;  // new finish wins over old pulse
        end else if (result_valid_o) begin
            finish_pending_q <= 1'b0;
        end
    end

    valid_is_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        result_valid_o |=> !result_valid_o)
        else begin
            assert_failed = 1'b1;
            $error("result_valid_o held longer than one cycle");
        end

    busy_falls_with_valid: assert property (@(posedge clk_i) disable iff (rst_i)
        result_valid_o |-> $fell(busy_o))
        else begin
            assert_failed = 1'b1;
            $error("busy_o did not fall with result_valid_o");
        end

    busy_falls_only_on_valid: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(busy_o) |-> result_valid_o)
        else begin
            assert_failed = 1'b1;
            $error("busy_o fell without a result");
        end

    valid_needs_finish: assert property (@(posedge clk_i) disable iff (rst_i)
        result_valid_o |-> finish_pending_q)
        else begin
            assert_failed = 1'b1;
            $error("result_valid_o without an accepted finish");
        end

endmodule

bind dot_product_top dot_product_properties props_u (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .cmd_valid_i    (cmd_valid_i),
    .op_i           (op_i),
    .busy_o         (busy_o),
    .result_valid_o (result_valid_o)
);

`default_nettype wire

/* source/dot_product_top.sv */
// two-lane dot product engine
`timescale 1ns/1ps
`default_nettype none

`include "dot_macros.svh"

module dot_product_top (
    input  wire logic                        clk_i,
    input  wire logic                        rst_i,
    input  wire logic                        cmd_valid_i,  // command strobe
    input  wire dot_pkg::opcode_e            op_i,
    input  wire logic signed [`DOT_IN_W-1:0] a0_i,         // even element pair
    input  wire logic signed [`DOT_IN_W-1:0] b0_i,
    input  wire logic signed [`DOT_IN_W-1:0] a1_i,         // odd element pair
    input  wire logic signed [`DOT_IN_W-1:0] b1_i,
    output logic signed [`DOT_ACC_W-1:0]     result_o,
    output logic                             result_valid_o,
    output logic                             overflow_o,
    output logic                             busy_o        // commands ignored while high
);

    logic emit;  // sequencer to combiner

    // one bundle per lane
    mac_lane_if lane_if [`DOT_LANES] ();

    dot_sequencer seq_u (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid_i),
        .op_i        (op_i),
        .busy_o      (busy_o),
        .emit_o      (emit),
        .lane0_o     (lane_if[0]),
        .lane1_o     (lane_if[1])
    );

    // lane 0, even elements
    mac_lane lane0_u (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .a_i    (a0_i),
        .b_i    (b0_i),
        .lane_i (lane_if[0])
    );

    // lane 1, odd elements
    mac_lane lane1_u (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .a_i    (a1_i),
        .b_i    (b1_i),
        .lane_i (lane_if[1])
    );

    lane_combiner comb_u (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .emit_i         (emit),
        .lane0_i        (lane_if[0]),
        .lane1_i        (lane_if[1]),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .overflow_o     (overflow_o)
    );

endmodule

`default_nettype wire

/* source/lane_combiner.sv */
// lane sum combiner with saturation
`timescale 1ns/1ps
`default_nettype none

`include "dot_macros.svh"

module lane_combiner (
    input  wire logic                    clk_i,
    input  wire logic                    rst_i,
    input  wire logic                    emit_i,          // from sequencer
    mac_lane_if.comb                     lane0_i,
    mac_lane_if.comb                     lane1_i,
    output logic signed [`DOT_ACC_W-1:0] result_o,
    output logic                         result_valid_o,  // one-cycle pulse
    output logic                         overflow_o
);

    // one guard bit per doubling of lanes
    localparam int SUM_W = `DOT_ACC_W + $clog2(`DOT_LANES);
    localparam logic signed [`DOT_ACC_W-1:0] ACC_MAX = {1'b0, {(`DOT_ACC_W-1){1'b1}}};
    localparam logic signed [`DOT_ACC_W-1:0] ACC_MIN = {1'b1, {(`DOT_ACC_W-1){1'b0}}};

    logic signed [SUM_W-1:0]           total;     // exact sum of both lanes
    logic [SUM_W-`DOT_ACC_W:0]         top_bits;  // guard bits plus result msb
    logic                              sat;       // total out of result range
    logic signed [`DOT_ACC_W-1:0]      clamped;
    logic signed [`DOT_ACC_W-1:0]      result_q;
    logic                              valid_q;
    logic                              ovf_q;     // flags captured at emit
    logic                              lane_ovf;

    assign total = SUM_W'(lane0_i.sum) + SUM_W'(lane1_i.sum);

    // fits only if all top bits agree
    assign top_bits = total[SUM_W-1:`DOT_ACC_W-1];
    assign sat      = (|top_bits) && !(&top_bits);

    always_comb begin
        if (!sat) begin
            clamped = total[`DOT_ACC_W-1:0];
        end else if (total[SUM_W-1]) begin
            clamped = ACC_MIN;  // negative overflow
        end else begin
            clamped = ACC_MAX;
        end
    end

    assign lane_ovf = lane0_i.ovf | lane1_i.ovf;

    // result payload, only meaningful with valid
    always_ff @(posedge clk_i) begin
        if (emit_i) begin
            result_q <= clamped;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            ovf_q   <= 1'b0;
        end else begin
            valid_q <= emit_i;  // emit is a single cycle
            if (emit_i) begin
                ovf_q <= lane_ovf | sat;
            end
        end
    end

    assign result_o       = result_q;
    assign result_valid_o = valid_q;
    assign overflow_o     = valid_q ? ovf_q : lane_ovf;  // live sticky flags otherwise

endmodule

`default_nettype wire

/* source/mac_lane.sv */
// signed multiply-accumulate lane
`timescale 1ns/1ps
`default_nettype none

`include "dot_macros.svh"

module mac_lane (
    input  wire logic                        clk_i,
    input  wire logic                        rst_i,
    input  wire logic signed [`DOT_IN_W-1:0] a_i,  // element from host
    input  wire logic signed [`DOT_IN_W-1:0] b_i,
    mac_lane_if.lane                         lane_i
);

    localparam int PROD_W = 2 * `DOT_IN_W;  // full precision product
    localparam int MSB = `DOT_ACC_W - 1;

    logic signed [`DOT_IN_W-1:0]  a_q;       // operands held from the accept edge
    logic signed [`DOT_IN_W-1:0]  b_q;
    logic signed [PROD_W-1:0]     prod_q;    // registered product
    logic                         en_q;      // acc_en delayed to match prod_q
    logic signed [`DOT_ACC_W-1:0] addend;    // product widened to accumulator
    logic signed [`DOT_ACC_W-1:0] acc_add;   // raw wrapped sum
    logic signed [`DOT_ACC_W-1:0] sum_next;
    logic signed [`DOT_ACC_W-1:0] sum_q;
    logic                         ovf_now;   // overflow on this add
    logic                         ovf_q;     // sticky until clear

    // capture every cycle, host drives operands alongside the command
    always_ff @(posedge clk_i) begin
        a_q <= a_i;
        b_q <= b_i;
    end

    // product stage, loads only when the lane is told to accumulate
    always_ff @(posedge clk_i) begin
        if (lane_i.acc_en) begin
            prod_q <= a_q * b_q;
        end
    end

    assign addend  = `DOT_ACC_W'(prod_q);  // sign extends if acc is wider
    assign acc_add = sum_q + addend;

    // same sign in, different sign out
    assign ovf_now = (sum_q[MSB] == addend[MSB]) && (acc_add[MSB] != sum_q[MSB]);

    always_comb begin
        if (lane_i.clear) begin
            sum_next = '0;       // clear wins over a pending add
        end else if (en_q) begin
            sum_next = acc_add;  // wraps on overflow, flag records it
        end else begin
            sum_next = sum_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            en_q  <= 1'b0;
            sum_q <= '0;
            ovf_q <= 1'b0;
        end else begin
            en_q  <= lane_i.acc_en;
            sum_q <= sum_next;
            if (lane_i.clear) begin
                ovf_q <= 1'b0;
            end else if (en_q && ovf_now) begin
                ovf_q <= 1'b1;  // stays set
            end
        end
    end

    assign lane_i.sum = sum_q;
    assign lane_i.ovf = ovf_q;

endmodule

`default_nettype wire

/* source/dot_sequencer.sv */
// dot product command sequencer
`timescale 1ns/1ps
`default_nettype none

module dot_sequencer (
    input  wire logic       clk_i,
    input  wire logic       rst_i,
    input  wire logic       cmd_valid_i,  // command strobe
    input  wire dot_pkg::opcode_e op_i,
    output logic            busy_o,       // high while draining or emitting
    output logic            emit_o,       // fires the combiner
    mac_lane_if.seq         lane0_o,
    mac_lane_if.seq         lane1_o
);

    localparam int DRAIN_CYCLES = 2;  // covers product plus accumulate stage
    localparam int CNT_W = $clog2(DRAIN_CYCLES);

    dot_pkg::seq_state_e state_q;
    dot_pkg::seq_state_e state_d;
    logic [CNT_W-1:0]    drain_cnt_q;  // cycles spent in drain
    logic                clear_q;      // registered clear strobe
    logic                acc_en_q;     // registered accumulate strobe
    logic                take;         // command accepted this cycle

    // commands only count in run state
    assign take = cmd_valid_i && (state_q == dot_pkg::ST_RUN);

    always_comb begin
        state_d = state_q;  // hold by default
        case (state_q)
            dot_pkg::ST_RUN: begin
                if (take && (op_i == dot_pkg::OP_FINISH)) begin
                    state_d = dot_pkg::ST_DRAIN;  // start drain, lanes keep their sums
                end
            end
            dot_pkg::ST_DRAIN: begin
                if (drain_cnt_q == CNT_W'(DRAIN_CYCLES - 1)) begin
                    state_d = dot_pkg::ST_EMIT;
                end
            end
            dot_pkg::ST_EMIT: begin
                state_d = dot_pkg::ST_RUN;  // single emit cycle
            end
            default: begin
                state_d = dot_pkg::ST_RUN;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= dot_pkg::ST_RUN;
            drain_cnt_q <= '0;
            clear_q     <= 1'b0;
            acc_en_q    <= 1'b0;
        end else begin
            state_q  <= state_d;
            clear_q  <= take && (op_i == dot_pkg::OP_CLEAR);  // one cycle after accept
            acc_en_q <= take && (op_i == dot_pkg::OP_ACCUM);
            if (state_q == dot_pkg::ST_DRAIN) begin
                drain_cnt_q <= drain_cnt_q + 1'b1;
            end else begin
                drain_cnt_q <= '0;  // rearm for next finish
            end
        end
    end

    assign busy_o = (state_q != dot_pkg::ST_RUN);
    assign emit_o = (state_q == dot_pkg::ST_EMIT);

    // both lanes see the same strobes
    assign lane0_o.clear  = clear_q;
    assign lane0_o.acc_en = acc_en_q;
    assign lane1_o.clear  = clear_q;
    assign lane1_o.acc_en = acc_en_q;

endmodule

`default_nettype wire

/* source/mac_lane_if.sv */
// mac lane bundle
`timescale 1ns/1ps
`default_nettype none

`include "dot_macros.svh"

interface mac_lane_if;

    logic                         clear;   // one-cycle clear strobe
    logic                         acc_en;  // one-cycle accumulate strobe
    logic signed [`DOT_ACC_W-1:0] sum;     // running lane sum
    logic                         ovf;     // sticky lane overflow

    // sequencer side
    modport seq (
        output clear,
        output acc_en
    );

    // lane side, takes strobes and reports its sum
    modport lane (
        input  clear,
        input  acc_en,
        output sum,
        output ovf
    );

    // combiner only observes
    modport comb (
        input sum,
        input ovf
    );

endinterface

`default_nettype wire

/* source/dot_pkg.sv */
// dot product shared types
`default_nettype none

package dot_pkg;

    // host command encoding, sampled with cmd_valid_i
    typedef enum logic [1:0] {
        OP_NOP    = 2'd0,  // idle cycle
        OP_CLEAR  = 2'd1,  // zero both lanes and their flags
        OP_ACCUM  = 2'd2,  // add a*b into each lane
        OP_FINISH = 2'd3   // drain and emit combined result
    } opcode_e;

    // sequencer states
    typedef enum logic [1:0] {
        ST_RUN   = 2'd0,  // accepting commands
        ST_DRAIN = 2'd1,  // waiting for lane pipelines to settle
        ST_EMIT  = 2'd2   // one cycle, fires the combiner
    } seq_state_e;

endpackage

`default_nettype wire

/* include/dot_macros.svh */
// dot product width macros
`ifndef DOT_MACROS_SVH
`define DOT_MACROS_SVH

// operand width of each element
`define DOT_IN_W 16

// lane accumulator and final result width
// a full 16x16 product fits without growth
`define DOT_ACC_W 32

// number of parallel mac lanes
// lane 0 takes even elements, lane 1 odd ones
`define DOT_LANES 2

`endif
